// File: source/cache_pkg.sv
package cache_pkg;

    // address and data geometry
    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int mask_w    = data_w / 8;
    localparam int num_lines = 16;
    localparam int index_w   = 4;
    localparam int offset_w  = 2;
    localparam int tag_w     = addr_w - index_w - offset_w;
    localparam int port_w    = 2;

    // client request, as it arrives on the input port
    typedef struct packed {
        logic                 cacheable;
        logic                 is_write;
        logic [port_w-1:0]    port;
        logic [mask_w-1:0]    byte_mask;
        logic [data_w-1:0]    data;
        logic [addr_w-1:0]    addr;
    } req_packet_t;

    typedef struct packed {
        logic [port_w-1:0]    port;
        logic                 is_write;
        logic                 error;
        logic [data_w-1:0]    data;
        logic [addr_w-1:0]    addr;
    } ret_packet_t;

    // request with its address already split for the array lookup
    typedef struct packed {
        req_packet_t          req;
        logic [tag_w-1:0]     tag;
        logic [index_w-1:0]   index;
    } decoded_req_t;

    typedef struct packed {
        logic                 is_write;
        logic [addr_w-1:0]    addr;
        logic [data_w-1:0]    data;
        logic [mask_w-1:0]    strb;
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0]    data;
        logic                 error;
    } mem_rsp_t;

endpackage

// File: source/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // master to slave
    typedef struct packed {
        // write address
        logic [31:0]  awaddr;
        logic [2:0]   awprot;
        logic         awvalid;
        // write data
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
        logic         wvalid;
        // write response
        logic         bready;
        // read address
        logic [31:0]  araddr;
        logic [2:0]   arprot;
        logic         arvalid;
        // read data
        logic         rready;
    } axi_lite_req_t;

    // slave to master
    typedef struct packed {
        logic         awready;
        logic         wready;
        logic [1:0]   bresp;
        logic         bvalid;
        logic         arready;
        logic [31:0]  rdata;
        logic [1:0]   rresp;
        logic         rvalid;
    } axi_lite_rsp_t;

endpackage

// File: source/packet_decode.sv
`timescale 1ns/1ps

module packet_decode
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    input  cache_pkg::req_packet_t  req_packet,
    input  logic                    req_valid,
    output logic                    req_ready,

    output cache_pkg::decoded_req_t dec_req,
    output logic                    dec_valid,
    input  logic                    dec_ready
);

    logic accept;

    // slot frees up when execute takes the held item
    assign req_ready = !dec_valid || dec_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            dec_valid <= 1'b0;
        end
        else if (accept)
        begin
            dec_valid <= 1'b1;
        end
        else if (dec_ready)
        begin
            dec_valid <= 1'b0;
        end
    end

    // address split: tag | index | byte offset
    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            dec_req.req   <= req_packet;
            dec_req.tag   <= req_packet.addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
            dec_req.index <= req_packet.addr[cache_pkg::offset_w +: cache_pkg::index_w];
        end
    end

endmodule

// File: source/cache_core.sv
`timescale 1ns/1ps

module cache_core
(
    input  logic                    clk_in,
    input  logic                    reset_in,

    input  cache_pkg::decoded_req_t dec_req,
    input  logic                    dec_valid,
    output logic                    dec_ready,

    output cache_pkg::mem_req_t     mem_req,
    output logic                    mem_req_valid,
    input  logic                    mem_req_ready,

    input  cache_pkg::mem_rsp_t     mem_rsp,
    input  logic                    mem_rsp_valid,

    output cache_pkg::ret_packet_t  res_packet,
    output logic                    res_valid,
    input  logic                    res_ready
);

    typedef enum logic [1:0] {st_idle, st_wait_mem, st_wait_res} state_t;

    state_t                           state;
    cache_pkg::decoded_req_t          cur;
    logic [cache_pkg::num_lines-1:0]  valid_bits;
    logic [cache_pkg::tag_w-1:0]      tag_arr  [cache_pkg::num_lines];
    logic [cache_pkg::data_w-1:0]     data_arr [cache_pkg::num_lines];

    logic take;
    logic lookup_hit;
    logic fast_hit;
    logic cur_hit;
    logic mem_done;
    logic rsp_ok;

    // next item can enter while the current result is leaving
    assign dec_ready  = (state == st_idle) || (state == st_wait_res && res_ready);
    assign take       = dec_valid && dec_ready;

    assign lookup_hit = valid_bits[dec_req.index] && (tag_arr[dec_req.index] == dec_req.tag);
    assign fast_hit   = dec_req.req.cacheable && !dec_req.req.is_write && lookup_hit;
    assign cur_hit    = valid_bits[cur.index] && (tag_arr[cur.index] == cur.tag);

    assign mem_done   = (state == st_wait_mem) && mem_rsp_valid;
    assign rsp_ok     = mem_done && !mem_rsp.error;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state         <= st_idle;
            res_valid     <= 1'b0;
            mem_req_valid <= 1'b0;
            valid_bits    <= '0;
        end
        else
        begin
            if (res_valid && res_ready)
            begin
                res_valid <= 1'b0;
                state     <= st_idle;
            end
            if (mem_req_valid && mem_req_ready)
            begin
                mem_req_valid <= 1'b0;
            end
            if (take)
            begin
                if (fast_hit)
                begin
                    res_valid <= 1'b1;
                    state     <= st_wait_res;
                end
                else
                begin
                    mem_req_valid <= 1'b1;
                    state         <= st_wait_mem;
                end
            end
            if (mem_done)
            begin
                res_valid <= 1'b1;
                state     <= st_wait_res;
            end
            // only a cacheable read miss allocates
            if (rsp_ok && cur.req.cacheable && !cur.req.is_write)
            begin
                valid_bits[cur.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (take)
        begin
            cur              <= dec_req;
            mem_req.is_write <= dec_req.req.is_write;
            mem_req.addr     <= dec_req.req.addr;
            mem_req.data     <= dec_req.req.data;
            mem_req.strb     <= dec_req.req.byte_mask;
            if (fast_hit)
            begin
                res_packet.port     <= dec_req.req.port;
                res_packet.is_write <= 1'b0;
                res_packet.error    <= 1'b0;
                res_packet.data     <= data_arr[dec_req.index];
                res_packet.addr     <= dec_req.req.addr;
            end
        end
        if (mem_done)
        begin
            res_packet.port     <= cur.req.port;
            res_packet.is_write <= cur.req.is_write;
            res_packet.error    <= mem_rsp.error;
            res_packet.data     <= cur.req.is_write ? cur.req.data : mem_rsp.data;
            res_packet.addr     <= cur.req.addr;
        end
        if (rsp_ok && cur.req.cacheable && !cur.req.is_write)
        begin
            tag_arr[cur.index]  <= cur.tag;
            data_arr[cur.index] <= mem_rsp.data;
        end
        // write hit keeps the line in step with memory
        if (rsp_ok && cur.req.is_write && cur_hit)
        begin
            for (int b = 0; b < cache_pkg::mask_w; b++)
            begin
                if (cur.req.byte_mask[b])
                begin
                    data_arr[cur.index][8*b +: 8] <= cur.req.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: source/mem_bridge.sv
`timescale 1ns/1ps

module mem_bridge
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  cache_pkg::mem_req_t         mem_req,
    input  logic                        mem_req_valid,
    output logic                        mem_req_ready,

    output cache_pkg::mem_rsp_t         mem_rsp,
    output logic                        mem_rsp_valid,

    output axi_lite_pkg::axi_lite_req_t m_axi_req,
    input  axi_lite_pkg::axi_lite_rsp_t m_axi_rsp
);

    cache_pkg::mem_req_t req_r;
    logic                busy;
    logic                awvalid;
    logic                wvalid;
    logic                bready;
    logic                arvalid;
    logic                rready;
    logic                accept;
    logic                b_done;
    logic                r_done;

    assign mem_req_ready = !busy;
    assign accept        = mem_req_valid && !busy;
    assign b_done        = bready && m_axi_rsp.bvalid;
    assign r_done        = rready && m_axi_rsp.rvalid;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            busy          <= 1'b0;
            awvalid       <= 1'b0;
            wvalid        <= 1'b0;
            bready        <= 1'b0;
            arvalid       <= 1'b0;
            rready        <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end
        else
        begin
            mem_rsp_valid <= 1'b0;
            if (accept)
            begin
                busy <= 1'b1;
                if (mem_req.is_write)
                begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                    bready  <= 1'b1;
                end
                else
                begin
                    arvalid <= 1'b1;
                end
            end
            // address and data channels complete independently
            if (awvalid && m_axi_rsp.awready)
            begin
                awvalid <= 1'b0;
            end
            if (wvalid && m_axi_rsp.wready)
            begin
                wvalid <= 1'b0;
            end
            if (arvalid && m_axi_rsp.arready)
            begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (b_done)
            begin
                bready        <= 1'b0;
                busy          <= 1'b0;
                mem_rsp_valid <= 1'b1;
            end
            if (r_done)
            begin
                rready        <= 1'b0;
                busy          <= 1'b0;
                mem_rsp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            req_r <= mem_req;
        end
        if (b_done)
        begin
            mem_rsp.data  <= '0;
            mem_rsp.error <= (m_axi_rsp.bresp != axi_lite_pkg::resp_okay);
        end
        if (r_done)
        begin
            mem_rsp.data  <= m_axi_rsp.rdata;
            mem_rsp.error <= (m_axi_rsp.rresp != axi_lite_pkg::resp_okay);
        end
    end

    always_comb
    begin
        m_axi_req.awaddr  = req_r.addr;
        m_axi_req.awprot  = 3'b000;
        m_axi_req.awvalid = awvalid;
        m_axi_req.wdata   = req_r.data;
        m_axi_req.wstrb   = req_r.strb;
        m_axi_req.wvalid  = wvalid;
        m_axi_req.bready  = bready;
        m_axi_req.araddr  = req_r.addr;
        m_axi_req.arprot  = 3'b000;
        m_axi_req.arvalid = arvalid;
        m_axi_req.rready  = rready;
    end

endmodule

// File: source/return_stage.sv
`timescale 1ns/1ps

module return_stage
(
    input  logic                   clk_in,
    input  logic                   reset_in,

    input  cache_pkg::ret_packet_t res_packet,
    input  logic                   res_valid,
    output logic                   res_ready,

    output cache_pkg::ret_packet_t ret_packet,
    output logic                   ret_valid,
    input  logic                   ret_ready
);

    logic load;

    // reload allowed in the cycle the held packet is taken
    assign res_ready = !ret_valid || ret_ready;
    assign load      = res_valid && res_ready;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            ret_valid <= 1'b0;
        end
        else if (load)
        begin
            ret_valid <= 1'b1;
        end
        else if (ret_ready)
        begin
            ret_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load)
        begin
            ret_packet <= res_packet;
        end
    end

endmodule

// File: source/unified_cache_axi_top.sv
`timescale 1ns/1ps

module unified_cache_axi_top
(
    input  logic                        clk_in,
    input  logic                        reset_in,

    input  cache_pkg::req_packet_t      req_packet,
    input  logic                        req_valid,
    output logic                        req_ready,

    output cache_pkg::ret_packet_t      ret_packet,
    output logic                        ret_valid,
    input  logic                        ret_ready,

    output axi_lite_pkg::axi_lite_req_t m_axi_req,
    input  axi_lite_pkg::axi_lite_rsp_t m_axi_rsp
);

    cache_pkg::decoded_req_t dec_req;
    logic                    dec_valid;
    logic                    dec_ready;

    cache_pkg::mem_req_t     mem_req;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    cache_pkg::mem_rsp_t     mem_rsp;
    logic                    mem_rsp_valid;

    cache_pkg::ret_packet_t  res_packet;
    logic                    res_valid;
    logic                    res_ready;

    packet_decode u_decode
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_packet (req_packet),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .dec_req    (dec_req),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready)
    );

    cache_core u_core
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .dec_req       (dec_req),
        .dec_valid     (dec_valid),
        .dec_ready     (dec_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .res_packet    (res_packet),
        .res_valid     (res_valid),
        .res_ready     (res_ready)
    );

    // single-beat AXI4-Lite access per memory request
    mem_bridge u_bridge
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp),
        .mem_rsp_valid (mem_rsp_valid),
        .m_axi_req     (m_axi_req),
        .m_axi_rsp     (m_axi_rsp)
    );

    return_stage u_return
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .res_packet (res_packet),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .ret_packet (ret_packet),
        .ret_valid  (ret_valid),
        .ret_ready  (ret_ready)
    );

endmodule

// File: testbench/mem_bridge_props.sv
`timescale 1ns/1ps

module mem_bridge_props
(
    input logic                        clk_in,
    input logic                        reset_in,
    input axi_lite_pkg::axi_lite_req_t m_axi_req,
    input axi_lite_pkg::axi_lite_rsp_t m_axi_rsp,
    input logic                        mem_rsp_valid
);

    int assert_fails = 0;

    aw_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        m_axi_req.awvalid && !m_axi_rsp.awready |=> m_axi_req.awvalid)
        else
        begin
            $error("awvalid dropped before awready");
            assert_fails++;
        end

    w_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        m_axi_req.wvalid && !m_axi_rsp.wready |=> m_axi_req.wvalid)
        else
        begin
            $error("wvalid dropped before wready");
            assert_fails++;
        end

    ar_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        m_axi_req.arvalid && !m_axi_rsp.arready |=> m_axi_req.arvalid)
        else
        begin
            $error("arvalid dropped before arready");
            assert_fails++;
        end

    // one transfer at a time
    no_overlap: assert property (@(posedge clk_in) disable iff (reset_in)
        !((m_axi_req.awvalid || m_axi_req.wvalid || m_axi_req.bready) &&
          (m_axi_req.arvalid || m_axi_req.rready)))
        else
        begin
            $error("read and write in progress together");
            assert_fails++;
        end

    rsp_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
        mem_rsp_valid |=> !mem_rsp_valid)
        else
        begin
            $error("mem_rsp_valid longer than one cycle");
            assert_fails++;
        end

endmodule

bind mem_bridge mem_bridge_props u_props
(
    .clk_in        (clk_in),
    .reset_in      (reset_in),
    .m_axi_req     (m_axi_req),
    .m_axi_rsp     (m_axi_rsp),
    .mem_rsp_valid (mem_rsp_valid)
);

// File: testbench/tb_unified_cache_axi.sv
`timescale 1ns/1ps

module tb_unified_cache_axi;

    localparam int num_req    = 300;
    localparam int max_cycles = num_req * 40;
    localparam int mem_words  = 64;
    localparam int drain_len  = 20;

    logic                        clk_in;
    logic                        reset_in;
    cache_pkg::req_packet_t      req_packet;
    logic                        req_valid;
    logic                        req_ready;
    cache_pkg::ret_packet_t      ret_packet;
    logic                        ret_valid;
    logic                        ret_ready;
    axi_lite_pkg::axi_lite_req_t m_axi_req;
    axi_lite_pkg::axi_lite_rsp_t m_axi_rsp;

    logic [31:0]                     seed;
    logic [31:0]                     mem     [mem_words];
    logic [31:0]                     ref_mem [mem_words];
    logic [25:0]                     mirror_tag [16];
    logic [15:0]                     mirror_valid;
    cache_pkg::ret_packet_t          exp_q [$];
    cache_pkg::mem_req_t             wr_q [$];
    cache_pkg::ret_packet_t          held_pkt;
    logic                            held_valid;
    logic                            req_fired;
    int errors;
    int cycles;
    int sent;
    int received;
    int drain;
    int ar_seen;
    int ar_expected;
    int err_ar_seen;
    int err_ar_expected;
    int aw_seen;
    int w_seen;
    int writes_sent;

    // slave channel state
    logic        aw_got;
    logic        w_got;
    logic        ar_got;
    logic        b_taken;
    logic        r_taken;
    int          aw_wait;
    int          w_wait;
    int          ar_wait;
    int          b_wait;
    int          r_wait;
    logic [31:0] aw_addr_r;
    logic [31:0] w_data_r;
    logic [3:0]  w_strb_r;
    logic [31:0] ar_addr_r;

    unified_cache_axi_top uut
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_packet (req_packet),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .ret_packet (ret_packet),
        .ret_valid  (ret_valid),
        .ret_ready  (ret_ready),
        .m_axi_req  (m_axi_req),
        .m_axi_rsp  (m_axi_rsp)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed ^ (seed >> 16);
    endfunction

    // upper half of the word range with byte address bit 5 set
    function automatic logic slave_error(input logic [31:0] addr);
        return addr[7] && addr[5];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
            begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        errors++;
        $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic pick_ready(input logic pending, inout int wait_cnt, output logic ready);
        if (!pending)
        begin
            wait_cnt = -1;
            ready    = 1'b0;
        end
        else
        begin
            // 0 to 3 cycle delay per beat
            if (wait_cnt < 0)
            begin
                wait_cnt = lcg_next() % 4;
            end
            ready = (wait_cnt == 0);
            if (wait_cnt > 0)
            begin
                wait_cnt--;
            end
        end
    endtask

    task automatic new_request();
        logic [31:0] r;
        r = lcg_next();
        req_packet.addr      = {24'h0, r[5:0], 2'b00};
        req_packet.is_write  = (r[9:8] == 2'b00);
        req_packet.cacheable = (r[11:10] != 2'b00);
        req_packet.port      = r[13:12];
        req_packet.byte_mask = r[17:14];
        req_packet.data      = lcg_next();
    endtask

    // expected result from the model at acceptance time
    task automatic model_accept(input cache_pkg::req_packet_t p);
        cache_pkg::ret_packet_t e;
        cache_pkg::mem_req_t    w;
        logic [5:0]             word;
        logic [3:0]             idx;
        logic [25:0]            tag;
        logic                   err;
        logic                   hit;
        word = p.addr[7:2];
        idx  = p.addr[5:2];
        tag  = p.addr[31:6];
        err  = slave_error(p.addr);
        hit  = p.cacheable && mirror_valid[idx] && (mirror_tag[idx] == tag);
        e.port     = p.port;
        e.is_write = p.is_write;
        e.error    = err;
        e.addr     = p.addr;
        if (p.is_write)
        begin
            e.data     = p.data;
            w.is_write = 1'b1;
            w.addr     = p.addr;
            w.data     = p.data;
            w.strb     = p.byte_mask;
            wr_q.push_back(w);
            writes_sent++;
            if (!err)
            begin
                ref_mem[word] = merge_bytes(ref_mem[word], p.data, p.byte_mask);
            end
        end
        else
        begin
            e.data = err ? 32'h0 : ref_mem[word];
            if (!hit)
            begin
                ar_expected++;
            end
            if (err)
            begin
                err_ar_expected++;
            end
            // error leaves the line as it was
            if (p.cacheable && !hit && !err)
            begin
                mirror_valid[idx] = 1'b1;
                mirror_tag[idx]   = tag;
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic sample_cycle();
        cache_pkg::ret_packet_t e;
        req_fired = req_valid && req_ready;
        if (req_fired)
        begin
            model_accept(req_packet);
            sent++;
        end
        if (ret_valid && held_valid && (ret_packet !== held_pkt))
        begin
            report_mismatch("ret_stable", held_pkt, ret_packet);
        end
        if (ret_valid && ret_ready)
        begin
            received++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("return packet arrived with no request outstanding");
            end
            else
            begin
                e = exp_q.pop_front();
                if (ret_packet !== e)
                begin
                    report_mismatch("ret_packet", e, ret_packet);
                end
            end
        end
        held_valid = ret_valid && !ret_ready;
        held_pkt   = ret_packet;

        if (m_axi_req.awvalid && m_axi_rsp.awready)
        begin
            aw_seen++;
            aw_got    = 1'b1;
            aw_addr_r = m_axi_req.awaddr;
            if (m_axi_req.awprot !== 3'b000)
            begin
                report_mismatch("awprot", 3'b000, m_axi_req.awprot);
            end
            if (wr_q.size() == 0)
            begin
                errors++;
                $display("write address handshake with no write request pending");
            end
            else if (m_axi_req.awaddr !== wr_q[0].addr)
            begin
                report_mismatch("aw_addr", wr_q[0].addr, m_axi_req.awaddr);
            end
        end
        if (m_axi_req.wvalid && m_axi_rsp.wready)
        begin
            w_seen++;
            w_got    = 1'b1;
            w_data_r = m_axi_req.wdata;
            w_strb_r = m_axi_req.wstrb;
            if (wr_q.size() == 0)
            begin
                errors++;
                $display("write data handshake with no write request pending");
            end
            else if ({m_axi_req.wdata, m_axi_req.wstrb} !== {wr_q[0].data, wr_q[0].strb})
            begin
                report_mismatch("w_data", {wr_q[0].data, wr_q[0].strb},
                                {m_axi_req.wdata, m_axi_req.wstrb});
            end
        end
        b_taken = m_axi_rsp.bvalid && m_axi_req.bready;
        if (b_taken)
        begin
            if (!slave_error(aw_addr_r))
            begin
                mem[aw_addr_r[7:2]] = merge_bytes(mem[aw_addr_r[7:2]], w_data_r, w_strb_r);
            end
            aw_got = 1'b0;
            w_got  = 1'b0;
            if (wr_q.size() != 0)
            begin
                void'(wr_q.pop_front());
            end
        end
        if (m_axi_req.arvalid && m_axi_rsp.arready)
        begin
            ar_seen++;
            ar_got    = 1'b1;
            ar_addr_r = m_axi_req.araddr;
            if (m_axi_req.arprot !== 3'b000)
            begin
                report_mismatch("arprot", 3'b000, m_axi_req.arprot);
            end
            if (slave_error(m_axi_req.araddr))
            begin
                err_ar_seen++;
            end
        end
        r_taken = m_axi_rsp.rvalid && m_axi_req.rready;
        if (r_taken)
        begin
            ar_got = 1'b0;
        end
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic        go;
        r = lcg_next();
        if (!req_valid || req_fired)
        begin
            req_valid = 1'b0;
            if (sent < num_req && r[1:0] != 2'b00)
            begin
                new_request();
                req_valid = 1'b1;
            end
        end
        ret_ready = (r[3:2] != 2'b00);

        pick_ready(m_axi_req.awvalid && !aw_got, aw_wait, go);
        m_axi_rsp.awready = go;
        pick_ready(m_axi_req.wvalid && !w_got, w_wait, go);
        m_axi_rsp.wready = go;
        pick_ready(m_axi_req.arvalid && !ar_got, ar_wait, go);
        m_axi_rsp.arready = go;

        if (b_taken)
        begin
            m_axi_rsp.bvalid = 1'b0;
        end
        pick_ready(aw_got && w_got && !m_axi_rsp.bvalid, b_wait, go);
        if (go)
        begin
            m_axi_rsp.bvalid = 1'b1;
            m_axi_rsp.bresp  = slave_error(aw_addr_r) ? axi_lite_pkg::resp_slverr
                                                      : axi_lite_pkg::resp_okay;
        end

        if (r_taken)
        begin
            m_axi_rsp.rvalid = 1'b0;
        end
        pick_ready(ar_got && !m_axi_rsp.rvalid && !r_taken, r_wait, go);
        if (go)
        begin
            m_axi_rsp.rvalid = 1'b1;
            m_axi_rsp.rdata  = slave_error(ar_addr_r) ? 32'h0 : mem[ar_addr_r[7:2]];
            m_axi_rsp.rresp  = slave_error(ar_addr_r) ? axi_lite_pkg::resp_slverr
                                                      : axi_lite_pkg::resp_okay;
        end
    endtask

    initial
    begin
        seed            = 32'd81974;
        reset_in        = 1'b1;
        req_valid       = 1'b0;
        req_packet      = '0;
        ret_ready       = 1'b0;
        m_axi_rsp       = '0;
        mirror_valid    = '0;
        held_valid      = 1'b0;
        held_pkt        = '0;
        req_fired       = 1'b0;
        aw_got          = 1'b0;
        w_got           = 1'b0;
        ar_got          = 1'b0;
        b_taken         = 1'b0;
        r_taken         = 1'b0;
        aw_wait         = -1;
        w_wait          = -1;
        ar_wait         = -1;
        b_wait          = -1;
        r_wait          = -1;
        errors          = 0;
        cycles          = 0;
        sent            = 0;
        received        = 0;
        drain           = 0;
        ar_seen         = 0;
        ar_expected     = 0;
        err_ar_seen     = 0;
        err_ar_expected = 0;
        aw_seen         = 0;
        w_seen          = 0;
        writes_sent     = 0;
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i]     = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
            ref_mem[i] = mem[i];
        end
        repeat (5) @(posedge clk_in);
        #1;
        reset_in = 1'b0;

        // extra cycles after the last return catch duplicates
        while ((received < num_req || drain < drain_len) && cycles < max_cycles)
        begin
            @(negedge clk_in);
            sample_cycle();
            if (received >= num_req)
            begin
                drain++;
            end
            @(posedge clk_in);
            #1;
            drive_cycle();
            cycles++;
        end

        if (cycles >= max_cycles)
        begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d returns", cycles, received,
                     num_req);
        end
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected return packets never arrived", exp_q.size());
        end
        if (ar_seen != ar_expected)
        begin
            report_mismatch("ar_count", ar_expected, ar_seen);
        end
        if (err_ar_seen != err_ar_expected)
        begin
            report_mismatch("error_ar_count", err_ar_expected, err_ar_seen);
        end
        if (aw_seen != writes_sent)
        begin
            report_mismatch("aw_count", writes_sent, aw_seen);
        end
        if (w_seen != writes_sent)
        begin
            report_mismatch("w_count", writes_sent, w_seen);
        end
        if (uut.u_bridge.u_props.assert_fails != 0)
        begin
            errors++;
            $display("AXI handshake assertions failed %0d times",
                     uut.u_bridge.u_props.assert_fails);
        end
        $display("errors %0d, returns %0d/%0d, ar %0d, aw %0d, w %0d, cycles %0d",
                 errors, received, num_req, ar_seen, aw_seen, w_seen, cycles);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/cache_pkg.sv
source/axi_lite_pkg.sv
source/packet_decode.sv
source/cache_core.sv
source/mem_bridge.sv
source/return_stage.sv
source/unified_cache_axi_top.sv
testbench/mem_bridge_props.sv
testbench/tb_unified_cache_axi.sv

// File: Bender.yml
package:
  name: unified_cache_axi

sources:
  - source/cache_pkg.sv
  - source/axi_lite_pkg.sv
  - source/packet_decode.sv
  - source/cache_core.sv
  - source/mem_bridge.sv
  - source/return_stage.sv
  - source/unified_cache_axi_top.sv
  - target: test
    files:
      - testbench/mem_bridge_props.sv
      - testbench/tb_unified_cache_axi.sv
